//--- cache_sync_pkg.sv
// shared line, info and state types for the fence.i sync subsystem, referenced by scoped names
`default_nettype none

package cache_sync_pkg;

  localparam int TAG_W  = 25;   // tag bits per line
  localparam int DATA_W = 512;  // one 64-byte line

  // per-line bookkeeping, valid on top
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } line_info_t;

  // unit moved dcache -> sync -> icache, 544 bits
  typedef struct packed {
    logic [1:0]        way_id;  // up to 4 ways
    logic [3:0]        blk_id;  // up to 16 blocks
    line_info_t        info;
    logic [DATA_W-1:0] data;
  } cache_line_t;

  // fence.i controller states
  typedef enum logic [1:0] {
    SYNC_IDLE     = 2'd0,  // waiting for a fence request
    SYNC_READ     = 2'd1,  // rreq up, waiting for a line or rack
    SYNC_WRITE    = 2'd2,  // pushing captured line into icache
    SYNC_PACK_ACK = 2'd3   // rpackack sent, wait for rpackreq to fall
  } sync_state_e;

  // dcache walker states
  typedef enum logic [1:0] {
    WALK_IDLE    = 2'd0,  // no fence in progress
    WALK_PRESENT = 2'd1,  // rpackreq high, line on rline
    WALK_DROP    = 2'd2,  // gap cycle with rpackreq low, picks next line
    WALK_DONE    = 2'd3   // all lines sent, rack held until rreq falls
  } walk_state_e;

endpackage

`default_nettype wire

//--- dcache_array.sv
// data cache storage with a cpu store port and a walker that feeds every line to the sync controller
`default_nettype none

module dcache_array #(
  parameter int NUM_WAYS = 4,  // at most 4
  parameter int NUM_BLKS = 16  // at most 16
) (
  input  logic                        clk,
  input  logic                        rst,

  // cpu store side
  input  logic                        i_st_we,
  input  cache_sync_pkg::cache_line_t i_st_line,   // written at its own way/blk

  // sync controller side
  input  logic                        i_rreq,      // held for the whole fence
  output logic                        o_rack,      // all lines done
  output logic                        o_rpackreq,  // line valid on o_rline
  input  logic                        i_rpackack,  // one-cycle pulse
  output cache_sync_pkg::cache_line_t o_rline
);

  // storage, valid bits split out so only they see reset
  logic                              valid_q [NUM_WAYS][NUM_BLKS];
  logic [cache_sync_pkg::TAG_W-1:0]  tag_q   [NUM_WAYS][NUM_BLKS];
  logic [cache_sync_pkg::DATA_W-1:0] data_q  [NUM_WAYS][NUM_BLKS];

  // walker
  cache_sync_pkg::walk_state_e walk_q;
  logic [2:0] way_cnt_q;  // one extra bit, reaches NUM_WAYS when past the end
  logic [3:0] blk_cnt_q;
  logic       walk_end;
  logic       blk_last;

  assign walk_end = (way_cnt_q == 3'(NUM_WAYS));      // counter passed last line
  assign blk_last = (blk_cnt_q == 4'(NUM_BLKS - 1));  // wrap point inside a way

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int b = 0; b < NUM_BLKS; b++) begin
          valid_q[w][b] <= 1'b0;
        end
      end
    end else if (i_st_we) begin
      valid_q[i_st_line.way_id][i_st_line.blk_id] <= i_st_line.info.valid;
    end
  end

  // tag and data, single-cycle store
  always_ff @(posedge clk) begin
    if (i_st_we) begin
      tag_q[i_st_line.way_id][i_st_line.blk_id]  <= i_st_line.info.tag;
      data_q[i_st_line.way_id][i_st_line.blk_id] <= i_st_line.data;
    end
  end

  // walker fsm, way-major order, one line per pack handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      walk_q     <= cache_sync_pkg::WALK_IDLE;
      way_cnt_q  <= 3'd0;
      blk_cnt_q  <= 4'd0;
      o_rpackreq <= 1'b0;
      o_rack     <= 1'b0;
    end else begin
      case (walk_q)
        cache_sync_pkg::WALK_IDLE: begin
          if (i_rreq) begin
            way_cnt_q <= 3'd0;                       // start at way 0 blk 0
            blk_cnt_q <= 4'd0;
            walk_q    <= cache_sync_pkg::WALK_DROP;  // drop state loads first line
          end
        end

        cache_sync_pkg::WALK_PRESENT: begin
          if (i_rpackack) begin
            o_rpackreq <= 1'b0;  // release for at least one cycle
            if (blk_last) begin
              blk_cnt_q <= 4'd0;
              way_cnt_q <= way_cnt_q + 3'd1;
            end else begin
              blk_cnt_q <= blk_cnt_q + 4'd1;
            end
            walk_q <= cache_sync_pkg::WALK_DROP;
          end
        end

        cache_sync_pkg::WALK_DROP: begin
          if (walk_end) begin
            o_rack <= 1'b1;
            walk_q <= cache_sync_pkg::WALK_DONE;
          end else begin
            o_rpackreq <= 1'b1;  // o_rline loads on the same edge
            walk_q     <= cache_sync_pkg::WALK_PRESENT;
          end
        end

        cache_sync_pkg::WALK_DONE: begin
          if (!i_rreq) begin  // controller saw rack
            o_rack <= 1'b0;
            walk_q <= cache_sync_pkg::WALK_IDLE;
          end
        end

        default: walk_q <= cache_sync_pkg::WALK_IDLE;
      endcase
    end
  end

  // line register, ids come from the walk position
  always_ff @(posedge clk) begin
    if (walk_q == cache_sync_pkg::WALK_DROP && !walk_end) begin
      o_rline.way_id     <= way_cnt_q[1:0];
      o_rline.blk_id     <= blk_cnt_q;
      o_rline.info.valid <= valid_q[way_cnt_q[1:0]][blk_cnt_q];
      o_rline.info.tag   <= tag_q[way_cnt_q[1:0]][blk_cnt_q];
      o_rline.data       <= data_q[way_cnt_q[1:0]][blk_cnt_q];
    end
  end

endmodule

`default_nettype wire

//--- icache_array.sv
// instruction cache storage with a sync write port and a registered fetch read port
`default_nettype none

module icache_array #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_BLKS = 16
) (
  input  logic                        clk,
  input  logic                        rst,

  // write port from the sync controller
  input  logic                        i_wreq,   // held until o_wack
  output logic                        o_wack,   // one pulse per request
  input  cache_sync_pkg::cache_line_t i_wline,

  // fetch port
  input  logic [1:0]                  i_fetch_way,
  input  logic [3:0]                  i_fetch_blk,
  output cache_sync_pkg::cache_line_t o_fetch_line  // one cycle after address
);

  logic                              valid_q [NUM_WAYS][NUM_BLKS];
  logic [1:0]                        way_q   [NUM_WAYS][NUM_BLKS];  // ids as written by the sync
  logic [3:0]                        blk_q   [NUM_WAYS][NUM_BLKS];
  logic [cache_sync_pkg::TAG_W-1:0]  tag_q   [NUM_WAYS][NUM_BLKS];
  logic [cache_sync_pkg::DATA_W-1:0] data_q  [NUM_WAYS][NUM_BLKS];
  logic                              wr_en;

  // no second write while the ack is still up
  assign wr_en = i_wreq & ~o_wack;

  // ack strobe and valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wack <= 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int b = 0; b < NUM_BLKS; b++) begin
          valid_q[w][b] <= 1'b0;
        end
      end
    end else begin
      o_wack <= wr_en;  // high for one cycle, drops while wreq still held
      if (wr_en) begin
        valid_q[i_wline.way_id][i_wline.blk_id] <= i_wline.info.valid;
      end
    end
  end

  // ids, tag and data
  always_ff @(posedge clk) begin
    if (wr_en) begin
      way_q[i_wline.way_id][i_wline.blk_id]  <= i_wline.way_id;
      blk_q[i_wline.way_id][i_wline.blk_id]  <= i_wline.blk_id;
      tag_q[i_wline.way_id][i_wline.blk_id]  <= i_wline.info.tag;
      data_q[i_wline.way_id][i_wline.blk_id] <= i_wline.data;
    end
  end

  // registered fetch read, returns old contents on a same-cycle write
  always_ff @(posedge clk) begin
    o_fetch_line.way_id     <= way_q[i_fetch_way][i_fetch_blk];
    o_fetch_line.blk_id     <= blk_q[i_fetch_way][i_fetch_blk];
    o_fetch_line.info.valid <= valid_q[i_fetch_way][i_fetch_blk];
    o_fetch_line.info.tag   <= tag_q[i_fetch_way][i_fetch_blk];
    o_fetch_line.data       <= data_q[i_fetch_way][i_fetch_blk];
  end

endmodule

`default_nettype wire

//--- cache_sync.sv
// fence.i controller, copies each dcache line into the same way and block of the icache
`default_nettype none

module cache_sync (
  input  logic                        clk,
  input  logic                        rst,

  // fence.i request side
  input  logic                        i_fencei_req,  // level, held until ack
  output logic                        o_fencei_ack,  // one-cycle pulse

  // dcache walker
  output logic                        o_rreq,      // read request, whole fence
  input  logic                        i_rack,      // read acknowledge
  input  logic                        i_rpackreq,  // pack request
  output logic                        o_rpackack,  // pack acknowledge, one cycle
  input  cache_sync_pkg::cache_line_t i_rline,

  // icache write port
  output logic                        o_wreq,   // write request
  input  logic                        i_wack,   // write acknowledge
  output cache_sync_pkg::cache_line_t o_wline   // captured line
);

  cache_sync_pkg::sync_state_e state_q;
  logic hs_rd;  // walker finished all lines
  logic hs_wr;  // icache took the line
  logic take_line;

  assign hs_rd     = o_rreq & i_rack;
  assign hs_wr     = o_wreq & i_wack;
  assign take_line = (state_q == cache_sync_pkg::SYNC_READ) & i_rpackreq;

  // fsm and control strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= cache_sync_pkg::SYNC_IDLE;
      o_fencei_ack <= 1'b0;
      o_rreq       <= 1'b0;
      o_rpackack   <= 1'b0;
      o_wreq       <= 1'b0;
    end else begin
      case (state_q)
        cache_sync_pkg::SYNC_IDLE: begin
          o_fencei_ack <= 1'b0;  // ack lasts one cycle
          // ignore the request still seen in the ack cycle
          if (i_fencei_req && !o_fencei_ack) begin
            state_q <= cache_sync_pkg::SYNC_READ;
          end
        end

        cache_sync_pkg::SYNC_READ: begin
          if (i_rpackreq) begin
            state_q <= cache_sync_pkg::SYNC_WRITE;  // line captured below
          end else if (hs_rd) begin
            o_fencei_ack <= 1'b1;
            o_rreq       <= 1'b0;
            state_q      <= cache_sync_pkg::SYNC_IDLE;
          end else begin
            o_rreq <= 1'b1;  // first read cycle raises it, then it just holds
          end
        end

        cache_sync_pkg::SYNC_WRITE: begin
          if (hs_wr) begin
            o_wreq     <= 1'b0;
            o_rpackack <= 1'b1;  // let the walker move on
            state_q    <= cache_sync_pkg::SYNC_PACK_ACK;
          end else begin
            o_wreq <= 1'b1;
          end
        end

        cache_sync_pkg::SYNC_PACK_ACK: begin
          o_rpackack <= 1'b0;
          // walker drops rpackreq a cycle after the ack
          if (!i_rpackreq) begin
            state_q <= cache_sync_pkg::SYNC_READ;
          end
        end

        default: state_q <= cache_sync_pkg::SYNC_IDLE;
      endcase
    end
  end

  // line capture on the cycle rpackreq is seen in read
  always_ff @(posedge clk) begin
    if (take_line) begin
      o_wline <= i_rline;
    end
  end

endmodule

`default_nettype wire

//--- fencei_sync_top.sv
// top level of the fence.i sync subsystem, ties dcache, controller and icache together
`default_nettype none

module fencei_sync_top #(
  parameter int NUM_WAYS = 4,  // at most 4
  parameter int NUM_BLKS = 16  // at most 16
) (
  input  logic                        clk,
  input  logic                        rst,

  // store port
  input  logic                        i_st_we,
  input  cache_sync_pkg::cache_line_t i_st_line,

  // fence port
  input  logic                        i_fencei_req,
  output logic                        o_fencei_ack,

  // fetch port
  input  logic [1:0]                  i_fetch_way,
  input  logic [3:0]                  i_fetch_blk,
  output cache_sync_pkg::cache_line_t o_fetch_line
);

  // dcache <-> controller
  logic                        rreq;
  logic                        rack;
  logic                        rpackreq;
  logic                        rpackack;
  cache_sync_pkg::cache_line_t rline;

  // controller <-> icache
  logic                        wreq;
  logic                        wack;
  cache_sync_pkg::cache_line_t wline;

  dcache_array #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_BLKS (NUM_BLKS)
  ) u_dcache (
    .clk        (clk),
    .rst        (rst),
    .i_st_we    (i_st_we),
    .i_st_line  (i_st_line),
    .i_rreq     (rreq),
    .o_rack     (rack),
    .o_rpackreq (rpackreq),
    .i_rpackack (rpackack),
    .o_rline    (rline)
  );

  cache_sync u_sync (
    .clk          (clk),
    .rst          (rst),
    .i_fencei_req (i_fencei_req),
    .o_fencei_ack (o_fencei_ack),
    .o_rreq       (rreq),
    .i_rack       (rack),
    .i_rpackreq   (rpackreq),
    .o_rpackack   (rpackack),
    .i_rline      (rline),
    .o_wreq       (wreq),
    .i_wack       (wack),
    .o_wline      (wline)
  );

  icache_array #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_BLKS (NUM_BLKS)
  ) u_icache (
    .clk          (clk),
    .rst          (rst),
    .i_wreq       (wreq),
    .o_wack       (wack),
    .i_wline      (wline),
    .i_fetch_way  (i_fetch_way),
    .i_fetch_blk  (i_fetch_blk),
    .o_fetch_line (o_fetch_line)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock and synchronous reset source, instanced once by the testbench top
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 100,  // time units per clock
  parameter int RST_CYCLES = 2     // rising edges with reset high
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;  // dut still sees reset on the last edge
  end

endmodule

`default_nettype wire

//--- tb_fencei_sync.sv
// testbench for fencei_sync_top, runs the command file fencei_sync_input.txt and checks fetches
`default_nettype none

module tb_fencei_sync;

  localparam int FENCE_TIMEOUT = 5000;  // cycles allowed for one fence
  localparam int QUIET_CYCLES  = 200;   // window that must stay free of a second ack
  localparam int RST_TIMEOUT   = 10;

  logic                        clk;
  logic                        rst;
  logic                        i_st_we;
  cache_sync_pkg::cache_line_t i_st_line;
  logic                        i_fencei_req;
  logic                        o_fencei_ack;
  logic [1:0]                  i_fetch_way;
  logic [3:0]                  i_fetch_blk;
  cache_sync_pkg::cache_line_t o_fetch_line;

  int           err_cnt   = 0;
  int           chk_cnt   = 0;
  int           fence_cnt = 0;    // fences acknowledged so far
  logic         timed_out = 1'b0;
  int           fd;
  int           code;
  int           n;
  logic         done;
  logic [7:0]   tok;          // command letter
  logic [127:0] name;         // test name column
  logic [1:0]   way;
  logic [3:0]   blk;
  logic [25:0]  info;
  logic [63:0]  pattern;      // repeated over the 512 data bits
  logic [1023:0] rest;        // tail of a comment line
  cache_sync_pkg::cache_line_t exp_line;
  cache_sync_pkg::cache_line_t got_line;

  tb_clk_gen #(
    .PERIOD     (100),
    .RST_CYCLES (2)
  ) u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  fencei_sync_top i_fencei_sync_top (
    .clk          (clk),
    .rst          (rst),
    .i_st_we      (i_st_we),
    .i_st_line    (i_st_line),
    .i_fencei_req (i_fencei_req),
    .o_fencei_ack (o_fencei_ack),
    .i_fetch_way  (i_fetch_way),
    .i_fetch_blk  (i_fetch_blk),
    .o_fetch_line (o_fetch_line)
  );

  // expected line from the file columns, ids follow the address
  function automatic cache_sync_pkg::cache_line_t make_line(input logic [1:0] l_way,
      input logic [3:0] l_blk, input logic [25:0] l_info, input logic [63:0] l_pat);
    cache_sync_pkg::cache_line_t l;
    l.way_id = l_way;
    l.blk_id = l_blk;
    l.info   = l_info;
    l.data   = {8{l_pat}};  // 8 x 64 = 512
    return l;
  endfunction

  // compare one field, count it
  task automatic compare_field(input logic [127:0] t_name, input logic [47:0] field,
                               input logic [511:0] exp, input logic [511:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("** Error %0s %0s: expected %0h, actual %0h", t_name, field, exp, act);
    end
  endtask

  task automatic store_line(input cache_sync_pkg::cache_line_t line);
    @(negedge clk);
    i_st_line = line;
    i_st_we   = 1'b1;
    @(negedge clk);
    i_st_we   = 1'b0;  // one write edge only
  endtask

  // address on one falling edge, registered result on the next
  task automatic fetch_line(input logic [1:0] f_way, input logic [3:0] f_blk,
                            output cache_sync_pkg::cache_line_t line);
    @(negedge clk);
    i_fetch_way = f_way;
    i_fetch_blk = f_blk;
    @(negedge clk);
    line = o_fetch_line;
  endtask

  task automatic run_fence(input logic [127:0] t_name);
    int   cyc;
    int   acks;
    logic seen;
    seen = 1'b0;
    cyc  = 0;
    @(negedge clk);
    i_fencei_req = 1'b1;
    while (!seen && cyc < FENCE_TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (o_fencei_ack === 1'b1) begin
        seen         = 1'b1;
        i_fencei_req = 1'b0;  // dropped before the next rising edge
      end
    end
    if (!seen) begin
      i_fencei_req = 1'b0;
      err_cnt++;
      timed_out = 1'b1;
      $display("timeout: no fence.i acknowledge within %0d cycles in %0s",
               FENCE_TIMEOUT, t_name);
    end else begin
      fence_cnt++;
      // single-cycle pulse, then silence
      acks = 0;
      for (cyc = 0; cyc < QUIET_CYCLES; cyc++) begin
        @(negedge clk);
        if (o_fencei_ack !== 1'b0) acks++;
      end
      compare_field(t_name, "acks", 512'd0, 512'(acks));
    end
  endtask

  task automatic end_run();
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    i_st_we      = 1'b0;
    i_st_line    = '0;
    i_fencei_req = 1'b0;
    i_fetch_way  = 2'd0;
    i_fetch_blk  = 4'd0;
    done         = 1'b0;
    n            = 0;
    while (rst !== 1'b0 && n < RST_TIMEOUT) begin  // wait out reset
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      err_cnt++;
      timed_out = 1'b1;
      $display("reset was never released by the clock generator");
    end
    fd = $fopen("fencei_sync_input.txt", "r");
    if (fd == 0 && !timed_out) begin
      err_cnt++;
      done = 1'b1;
      $display("could not open the command file fencei_sync_input.txt");
    end
    while (!done && !timed_out) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        done = 1'b1;  // end of file
      end else if (tok == "#") begin
        code = $fgets(rest, fd);  // comment line
      end else if (tok == "S") begin
        code = $fscanf(fd, "%s %h %h %h %h", name, way, blk, info, pattern);
        store_line(make_line(way, blk, info, pattern));
      end else if (tok == "F") begin
        code = $fscanf(fd, "%s", name);
        run_fence(name);
      end else if (tok == "C") begin
        code = $fscanf(fd, "%s %h %h %h %h", name, way, blk, info, pattern);
        exp_line = make_line(way, blk, info, pattern);
        fetch_line(way, blk, got_line);
        compare_field(name, "ids", 512'({exp_line.way_id, exp_line.blk_id}),
                      512'({got_line.way_id, got_line.blk_id}));
        compare_field(name, "info", 512'(exp_line.info), 512'(got_line.info));
        compare_field(name, "data", exp_line.data, got_line.data);
        compare_field(name, "ack", 512'd0, 512'(o_fencei_ack));  // no fence running
      end else if (tok == "V") begin
        code = $fscanf(fd, "%s %h %h", name, way, blk);
        fetch_line(way, blk, got_line);
        compare_field(name, "valid", 512'd0, 512'(got_line.info.valid));
        if (fence_cnt > 0) begin
          // a fence copies every line, so ids are there even if never stored
          compare_field(name, "ids", 512'({way, blk}),
                        512'({got_line.way_id, got_line.blk_id}));
        end
        compare_field(name, "ack", 512'd0, 512'(o_fencei_ack));
      end else begin
        err_cnt++;
        done = 1'b1;
        $display("unknown command in fencei_sync_input.txt, stopping the run");
      end
    end
    if (fd != 0) $fclose(fd);
    end_run();
  end

endmodule

`default_nettype wire

//--- fencei_sync_input.txt
# cmd name way blk info(valid bit 25 + 25-bit tag, hex) data(64-bit hex, repeated 8 times)
# S store, F fence, C fetch and compare whole line, V fetch and expect valid clear
V rst_w0b0 0 0
V rst_w3b15 3 f
V rst_w2b7 2 7
S st_w0b0 0 0 2000010 0123456789abcdef
S st_w1b5 1 5 2000155 a5a5a5a55a5a5a5a
S st_w3b15 3 f 1ffffff ffffffff00000000
S st_w2b9 2 9 0000abc 1122334455667788
V pre_fence_w0b0 0 0
V pre_fence_w1b5 1 5
F fence_1
C cp_w0b0 0 0 2000010 0123456789abcdef
C cp_w1b5 1 5 2000155 a5a5a5a55a5a5a5a
C cp_w3b15 3 f 1ffffff ffffffff00000000
C cp_w2b9 2 9 0000abc 1122334455667788
V unst_w1b0 1 0
V unst_w3b14 3 e
S new_w1b5 1 5 2000255 deadbeefcafef00d
S new_w0b0 0 0 2001000 0f0f0f0f0f0f0f0f
C old_w1b5 1 5 2000155 a5a5a5a55a5a5a5a
C old_w0b0 0 0 2000010 0123456789abcdef
F fence_2
C new_w1b5 1 5 2000255 deadbeefcafef00d
C new_w0b0 0 0 2001000 0f0f0f0f0f0f0f0f
C keep_w3b15 3 f 1ffffff ffffffff00000000
C keep_w2b9 2 9 0000abc 1122334455667788
V keep_w1b0 1 0

//--- all.f
cache_sync_pkg.sv
dcache_array.sv
icache_array.sv
cache_sync.sv
fencei_sync_top.sv
tb_clk_gen.sv
tb_fencei_sync.sv

//--- Bender.yml
package:
  name: fencei_sync

sources:
  - cache_sync_pkg.sv
  - dcache_array.sv
  - icache_array.sv
  - cache_sync.sv
  - fencei_sync_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_fencei_sync.sv
